//--- machine_pkg.sv
package machine_pkg;

   typedef logic [15:0] addr_t;   // host byte address
   typedef logic [31:0] word_t;   // bus data word
   typedef logic [7:0]  byte_t;   // peripheral data byte
   typedef logic [3:0]  wmask_t;  // one enable per byte of wdata

   typedef struct packed {
      logic   ren;
      logic   wen;
      addr_t  addr;
      word_t  wdata;
      wmask_t wmask;
   } bus_req_t;

   typedef struct packed {
      logic  rd_valid;
      word_t rdata;
   } bus_rsp_t;

   // region tags, compared against the top address bits
   localparam logic [1:0] bram_base  = 2'b00;   // addr[15:14]
   localparam logic [3:0] led_base   = 4'b0100; // addr[15:12]
   localparam logic [3:0] uart_base  = 4'b0101; // addr[15:12]
   localparam logic       spram_base = 1'b1;    // addr[15]
   // 0x6000 to 0x7fff matches none of them

   localparam logic [2:0] uart_data_off   = 3'd0;
   localparam logic [2:0] uart_status_off = 3'd4;

   typedef enum logic [1:0] {
      idle,
      start,
      data,
      stop
   } uart_state_t;

endpackage

//--- bus_decoder.sv
module bus_decoder (
   input  logic                  clk,
   input  logic                  reset,
   input  machine_pkg::bus_req_t host_req,
   output machine_pkg::bus_rsp_t host_rsp,
   output machine_pkg::bus_req_t bram_req,
   input  machine_pkg::bus_rsp_t bram_rsp,
   output machine_pkg::bus_req_t spram_req,
   input  machine_pkg::bus_rsp_t spram_rsp,
   output machine_pkg::bus_req_t led_req,
   input  machine_pkg::bus_rsp_t led_rsp,
   output machine_pkg::bus_req_t uart_req,
   input  machine_pkg::bus_rsp_t uart_rsp
);

   logic       bram_sel;
   logic       spram_sel;
   logic       led_sel;
   logic       uart_sel;
   logic       none_sel;
   logic [4:0] rd_sel; // {none, uart, led, spram, bram}, one-hot for the read in flight

   // address, data and mask go everywhere, strobes only to the selected device
   function automatic machine_pkg::bus_req_t gate_req(input machine_pkg::bus_req_t req,
                                                      input logic sel);
      machine_pkg::bus_req_t r;
      r     = req;
      r.ren = req.ren & sel;
      r.wen = req.wen & sel;
      return r;
   endfunction

   always_comb begin
      bram_sel  = (host_req.addr[15:14] == machine_pkg::bram_base);
      led_sel   = (host_req.addr[15:12] == machine_pkg::led_base);
      uart_sel  = (host_req.addr[15:12] == machine_pkg::uart_base);
      spram_sel = (host_req.addr[15] == machine_pkg::spram_base);
      none_sel  = !(bram_sel || led_sel || uart_sel || spram_sel);
   end

   assign bram_req  = gate_req(host_req, bram_sel);
   assign spram_req = gate_req(host_req, spram_sel);
   assign led_req   = gate_req(host_req, led_sel);
   assign uart_req  = gate_req(host_req, uart_sel);

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_sel <= '0;
      end else if (host_req.ren) begin
         rd_sel <= {none_sel, uart_sel, led_sel, spram_sel, bram_sel};
      end else begin
         rd_sel <= '0;
      end
   end

   always_comb begin
      host_rsp = '0;
      case (1'b1)
         rd_sel[0]: host_rsp = bram_rsp;
         rd_sel[1]: host_rsp = spram_rsp;
         rd_sel[2]: host_rsp = led_rsp;
         rd_sel[3]: host_rsp = uart_rsp;
         rd_sel[4]: host_rsp.rd_valid = 1'b1; // unmapped, data stays zero
         default:   host_rsp = '0;
      endcase
   end

endmodule

//--- ram.sv
module ram #(
   parameter int addr_bits = 13
) (
   input  logic                  clk,
   input  logic                  reset,
   input  machine_pkg::bus_req_t req,
   output machine_pkg::bus_rsp_t rsp
);

   localparam int words = 2 ** (addr_bits - 2);

   machine_pkg::word_t mem [words];
   logic [addr_bits-3:0] index;
   machine_pkg::word_t   rdata_q;
   logic                 rd_valid_q;

   assign index = req.addr[addr_bits-1:2]; // upper bits alias

   always_ff @(posedge clk) begin
      if (req.wen) begin
         for (int i = 0; i < 4; i++) begin
            if (req.wmask[i]) begin
               mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
            end
         end
      end
      if (req.ren) begin
         rdata_q <= mem[index];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= req.ren;
      end
   end

   assign rsp = '{rd_valid: rd_valid_q, rdata: rdata_q};

endmodule

//--- led.sv
module led (
   input  logic                  clk,
   input  logic                  reset,
   input  machine_pkg::bus_req_t req,
   output machine_pkg::bus_rsp_t rsp,
   output logic                  led1,
   output logic                  led2,
   output logic                  led3
);

   logic [2:0]         leds;
   logic               reg_hit;
   machine_pkg::byte_t wbyte;
   machine_pkg::byte_t rdata_q;
   logic               rd_valid_q;

   assign reg_hit = (req.addr[4:0] == 5'd0); // single register at offset 0
   assign wbyte   = req.wdata[7:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         leds <= 3'b000;
      end else if (req.wen && req.wmask[0] && reg_hit) begin
         leds <= wbyte[2:0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= req.ren;
      end
   end

   always_ff @(posedge clk) begin
      if (req.ren) begin
         rdata_q <= reg_hit ? {5'b00000, leds} : '0;
      end
   end

   assign rsp  = '{rd_valid: rd_valid_q, rdata: machine_pkg::word_t'(rdata_q)};
   assign led1 = leds[0];
   assign led2 = leds[1];
   assign led3 = leds[2];

endmodule

//--- uart.sv
module uart #(
   parameter int clks_per_bit = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  machine_pkg::bus_req_t req,
   output machine_pkg::bus_rsp_t rsp,
   output logic                  tx,
   input  logic                  rx
);

   localparam int cnt_bits = $clog2(clks_per_bit + 1);
   localparam logic [cnt_bits-1:0] last_count = cnt_bits'(clks_per_bit - 1);
   localparam logic [cnt_bits-1:0] half_count = cnt_bits'(clks_per_bit / 2 - 1);

   machine_pkg::uart_state_t tx_state;
   logic [cnt_bits-1:0]      tx_count;
   logic [2:0]               tx_bit;
   machine_pkg::byte_t       tx_shift;
   logic                     tx_busy;
   logic                     tx_start;

   machine_pkg::uart_state_t rx_state;
   logic [cnt_bits-1:0]      rx_count;
   logic [2:0]               rx_bit;
   machine_pkg::byte_t       rx_shift;
   machine_pkg::byte_t       rx_byte;
   logic                     rx_valid;
   logic                     rx_meta;
   logic                     rx_sync;
   logic                     data_read;

   machine_pkg::word_t rdata_q;
   logic               rd_valid_q;

   assign tx_busy   = (tx_state != machine_pkg::idle);
   assign tx_start  = req.wen && req.wmask[0] && !tx_busy
                      && (req.addr[2:0] == machine_pkg::uart_data_off); // busy writes dropped
   assign data_read = req.ren && (req.addr[2:0] == machine_pkg::uart_data_off);

   always_ff @(posedge clk) begin
      if (reset) begin
         tx_state <= machine_pkg::idle;
         tx       <= 1'b1;
         tx_count <= '0;
         tx_bit   <= '0;
      end else begin
         case (tx_state)
            machine_pkg::idle: begin
               if (tx_start) begin
                  tx_shift <= req.wdata[7:0];
                  tx       <= 1'b0; // start bit
                  tx_count <= '0;
                  tx_state <= machine_pkg::start;
               end
            end
            machine_pkg::start: begin
               if (tx_count == last_count) begin
                  tx_count <= '0;
                  tx_bit   <= '0;
                  tx       <= tx_shift[0];
                  tx_state <= machine_pkg::data;
               end else begin
                  tx_count <= tx_count + 1'b1;
               end
            end
            machine_pkg::data: begin
               if (tx_count == last_count) begin
                  tx_count <= '0;
                  if (tx_bit == 3'd7) begin
                     tx       <= 1'b1; // stop bit
                     tx_state <= machine_pkg::stop;
                  end else begin
                     tx_bit   <= tx_bit + 1'b1;
                     tx_shift <= tx_shift >> 1;
                     tx       <= tx_shift[1];
                  end
               end else begin
                  tx_count <= tx_count + 1'b1;
               end
            end
            machine_pkg::stop: begin
               if (tx_count == last_count) begin
                  tx_state <= machine_pkg::idle;
               end else begin
                  tx_count <= tx_count + 1'b1;
               end
            end
            default: tx_state <= machine_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rx_state <= machine_pkg::idle;
         rx_count <= '0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end else begin
         if (data_read) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            machine_pkg::idle: begin
               if (!rx_sync) begin
                  rx_count <= '0;
                  rx_state <= machine_pkg::start;
               end
            end
            machine_pkg::start: begin
               if (rx_count == half_count) begin // middle of start bit
                  rx_count <= '0;
                  rx_bit   <= '0;
                  rx_state <= rx_sync ? machine_pkg::idle : machine_pkg::data;
               end else begin
                  rx_count <= rx_count + 1'b1;
               end
            end
            machine_pkg::data: begin
               if (rx_count == last_count) begin
                  rx_count <= '0;
                  rx_shift <= {rx_sync, rx_shift[7:1]}; // lsb first
                  if (rx_bit == 3'd7) begin
                     rx_state <= machine_pkg::stop;
                  end else begin
                     rx_bit <= rx_bit + 1'b1;
                  end
               end else begin
                  rx_count <= rx_count + 1'b1;
               end
            end
            machine_pkg::stop: begin
               if (rx_count == last_count) begin
                  if (rx_sync) begin // framing ok
                     rx_byte  <= rx_shift;
                     rx_valid <= 1'b1;
                  end
                  rx_state <= machine_pkg::idle;
               end else begin
                  rx_count <= rx_count + 1'b1;
               end
            end
            default: rx_state <= machine_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= req.ren;
      end
   end

   always_ff @(posedge clk) begin
      if (req.ren) begin
         case (req.addr[2:0])
            machine_pkg::uart_data_off:   rdata_q <= machine_pkg::word_t'(rx_byte);
            machine_pkg::uart_status_off: rdata_q <= {30'd0, rx_valid, tx_busy};
            default:                      rdata_q <= '0;
         endcase
      end
   end

   assign rsp = '{rd_valid: rd_valid_q, rdata: rdata_q};

endmodule

//--- machine.sv
module machine #(
   parameter int clks_per_bit = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  machine_pkg::bus_req_t host_req,
   output machine_pkg::bus_rsp_t host_rsp,
   output logic                  led1,
   output logic                  led2,
   output logic                  led3,
   output logic                  uart_tx,
   input  logic                  uart_rx
);

   machine_pkg::bus_req_t bram_req;
   machine_pkg::bus_rsp_t bram_rsp;
   machine_pkg::bus_req_t spram_req;
   machine_pkg::bus_rsp_t spram_rsp;
   machine_pkg::bus_req_t led_req;
   machine_pkg::bus_rsp_t led_rsp;
   machine_pkg::bus_req_t uart_req;
   machine_pkg::bus_rsp_t uart_rsp;

   bus_decoder bus_decoder0 (
      .clk      (clk),
      .reset    (reset),
      .host_req (host_req),
      .host_rsp (host_rsp),
      .bram_req (bram_req),
      .bram_rsp (bram_rsp),
      .spram_req(spram_req),
      .spram_rsp(spram_rsp),
      .led_req  (led_req),
      .led_rsp  (led_rsp),
      .uart_req (uart_req),
      .uart_rsp (uart_rsp)
   );

   ram #(.addr_bits(13)) bram0 ( // 8 KB block ram
      .clk  (clk),
      .reset(reset),
      .req  (bram_req),
      .rsp  (bram_rsp)
   );

   ram #(.addr_bits(15)) spram0 ( // 32 KB
      .clk  (clk),
      .reset(reset),
      .req  (spram_req),
      .rsp  (spram_rsp)
   );

   led led0 (
      .clk  (clk),
      .reset(reset),
      .req  (led_req),
      .rsp  (led_rsp),
      .led1 (led1),
      .led2 (led2),
      .led3 (led3)
   );

   uart #(.clks_per_bit(clks_per_bit)) uart0 (
      .clk  (clk),
      .reset(reset),
      .req  (uart_req),
      .rsp  (uart_rsp),
      .tx   (uart_tx),
      .rx   (uart_rx)
   );

endmodule

//--- tb_clock.sv
module tb_clock (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

//--- machine_assertions.sv
module machine_assertions (
   input logic                  clk,
   input logic                  reset,
   input machine_pkg::bus_req_t host_req,
   input machine_pkg::bus_rsp_t host_rsp,
   input machine_pkg::bus_req_t bram_req,
   input machine_pkg::bus_req_t spram_req,
   input machine_pkg::bus_req_t led_req,
   input machine_pkg::bus_req_t uart_req,
   input logic                  led1,
   input logic                  led2,
   input logic                  led3
);
   timeunit 1ns;
   timeprecision 100ps;

   int         fail_count = 0; // read by the testbench at the end
   logic [3:0] strobes;

   assign strobes = {bram_req.ren | bram_req.wen, spram_req.ren | spram_req.wen,
                     led_req.ren | led_req.wen, uart_req.ren | uart_req.wen};

   rsp_after_read: assert property (@(posedge clk) disable iff (reset)
      host_req.ren |=> host_rsp.rd_valid)
   else begin
      $error("read not answered in the next cycle");
      fail_count++;
   end

   rsp_only_after_read: assert property (@(posedge clk) disable iff (reset)
      host_rsp.rd_valid |-> $past(host_req.ren))
   else begin
      $error("read response without a read in the cycle before");
      fail_count++;
   end

   one_device: assert property (@(posedge clk) disable iff (reset) $onehot0(strobes))
   else begin
      $error("more than one device selected");
      fail_count++;
   end

   leds_off: assert property (@(posedge clk) $fell(reset) |-> ({led3, led2, led1} == 3'b000))
   else begin
      $error("leds not off after reset");
      fail_count++;
   end

endmodule

bind machine machine_assertions checks (.*);

//--- machine_tb.sv
module machine_tb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic               check; // compare rdata against data
      logic [31:0]        due;   // cycle in which the response must show
      machine_pkg::word_t data;
   } pending_t;

   logic                  clk;
   logic                  reset;
   machine_pkg::bus_req_t host_req;
   machine_pkg::bus_rsp_t host_rsp;
   logic [2:0]            leds;
   logic                  serial; // tx looped back to rx

   machine_pkg::word_t ram_model [int];
   logic [2:0]         led_model = 3'b000;
   pending_t           pend_q [$];
   machine_pkg::addr_t written_q [$];
   machine_pkg::word_t last_rdata;
   logic [31:0]        cycles = '0;
   int                 errors = 0;
   int                 errors_at_start = 0;
   int                 tests_passed = 0;
   int                 tests_failed = 0;
   string              test_name = "reset";

   tb_clock clock0 (.clk(clk), .reset(reset));

   machine #(.clks_per_bit(8)) uut (
      .clk     (clk),
      .reset   (reset),
      .host_req(host_req),
      .host_rsp(host_rsp),
      .led1    (leds[0]),
      .led2    (leds[1]),
      .led3    (leds[2]),
      .uart_tx (serial),
      .uart_rx (serial)
   );

   // 0 bram, 1 spram, 2 led, 3 uart, 4 unmapped
   function automatic int region_of(input machine_pkg::addr_t a);
      if (a[15]) return 1;
      if (!a[14]) return 0;
      if (a[13:12] == 2'b00) return 2;
      if (a[13:12] == 2'b01) return 3;
      return 4;
   endfunction

   function automatic int ram_key(input machine_pkg::addr_t a);
      return a[15] ? 32'h10000 + int'(a[14:2]) : int'(a[12:2]); // spram keys above bram
   endfunction

   function automatic machine_pkg::word_t expect_read(input machine_pkg::addr_t a);
      case (region_of(a))
         0, 1:    return ram_model[ram_key(a)];
         2:       return (a[4:0] == 5'd0) ? {29'd0, led_model} : 32'd0;
         default: return 32'd0;
      endcase
   endfunction

   function automatic machine_pkg::addr_t pick_written();
      return written_q[$urandom_range(written_q.size() - 1)];
   endfunction

   task automatic report_mismatch(input machine_pkg::word_t exp, input machine_pkg::word_t act);
      $display("ERROR %s expected %h actual %h", test_name, exp, act);
      errors++;
   endtask

   task automatic report_problem(input string what);
      $display("ERROR %s: %s", test_name, what);
      errors++;
   endtask

   task automatic issue(input logic ren, input logic wen, input machine_pkg::addr_t addr,
                        input machine_pkg::word_t wdata, input machine_pkg::wmask_t wmask,
                        input logic check, input machine_pkg::word_t exp);
      @(posedge clk);
      #1;
      host_req = '{ren: ren, wen: wen, addr: addr, wdata: wdata, wmask: wmask};
      if (ren) begin
         pend_q.push_back('{check: check, due: cycles + 32'd1, data: exp});
      end
   endtask

   task automatic bus_idle();
      issue(1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
   endtask

   task automatic write_word(input machine_pkg::addr_t a, input machine_pkg::word_t d,
                             input machine_pkg::wmask_t m);
      machine_pkg::word_t w;
      issue(1'b0, 1'b1, a, d, m, 1'b0, '0);
      if (region_of(a) <= 1) begin
         w = ram_model.exists(ram_key(a)) ? ram_model[ram_key(a)] : 32'd0;
         for (int i = 0; i < 4; i++) begin
            if (m[i]) w[8*i +: 8] = d[8*i +: 8]; // masked merge
         end
         ram_model[ram_key(a)] = w;
      end else if (region_of(a) == 2 && m[0] && a[4:0] == 5'd0) begin
         led_model = d[2:0];
      end
   endtask

   task automatic read_word(input machine_pkg::addr_t a);
      issue(1'b1, 1'b0, a, '0, '0, 1'b1, expect_read(a));
   endtask

   task automatic read_checked(input machine_pkg::addr_t a, input machine_pkg::word_t exp);
      issue(1'b1, 1'b0, a, '0, '0, 1'b1, exp);
   endtask

   task automatic read_now(input machine_pkg::addr_t a, output machine_pkg::word_t d);
      issue(1'b1, 1'b0, a, '0, '0, 1'b0, '0);
      bus_idle();
      while (pend_q.size() != 0) @(posedge clk);
      d = last_rdata;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      bus_idle();
      while (pend_q.size() != 0) @(posedge clk);
      if (errors == errors_at_start) begin
         tests_passed++;
         $display("%s: ok", test_name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   // about 1900 bus cycles in all, the limit leaves a wide margin
   always @(posedge clk) begin
      cycles <= cycles + 32'd1;
      if (cycles == 32'd20000) begin
         $display("timeout: run stopped at the cycle limit");
         $display("sim failed");
         $finish;
      end
   end

   always @(negedge clk) begin
      pending_t p;
      if (!reset && host_rsp.rd_valid) begin
         assert (pend_q.size() != 0) else report_problem("read response with no read pending");
         if (pend_q.size() != 0) begin
            p = pend_q.pop_front();
            last_rdata = host_rsp.rdata;
            assert (p.due == cycles) else report_problem("read response in the wrong cycle");
            if (p.check) begin
               assert (host_rsp.rdata === p.data) else report_mismatch(p.data, host_rsp.rdata);
            end
         end
      end else if (pend_q.size() != 0 && pend_q[0].due <= cycles) begin
         p = pend_q.pop_front();
         report_problem("read got no response");
      end
   end

   initial begin
      machine_pkg::addr_t a;
      machine_pkg::word_t d;
      machine_pkg::byte_t b;
      int                 polls;
      host_req = '0;
      void'($urandom(32'hc011c6e2));
      wait (reset === 1'b0);

      begin_test("ram_masks");
      repeat (300) begin
         if (written_q.size() != 0 && $urandom_range(1) == 1) begin
            write_word(pick_written(), $urandom, 4'($urandom));
         end else begin
            a = $urandom_range(1) ? {1'b1, 15'($urandom)} : {2'b00, 14'($urandom)};
            a[1:0] = 2'b00;
            if (!ram_model.exists(ram_key(a))) written_q.push_back(a);
            write_word(a, $urandom, 4'hf); // whole word on first touch
         end
      end
      repeat (300) read_word(pick_written());
      end_test();

      begin_test("aliasing");
      repeat (40) begin
         a = pick_written();
         write_word(a, $urandom, 4'hf);
         if (a[15]) read_word({a[15:2], 2'($urandom)});
         else read_word({a[15:14], ~a[13], a[12:2], 2'($urandom)});
         read_word(pick_written());
      end
      read_word(16'h4000);
      end_test();

      begin_test("unmapped");
      repeat (50) read_word({3'b011, 13'($urandom)});
      end_test();

      begin_test("led");
      repeat (30) begin
         a = {4'b0100, 7'($urandom), 5'd0};
         write_word(a, $urandom, 4'($urandom));
         read_word(a);
         assert (leds === led_model) else report_mismatch({29'd0, led_model}, {29'd0, leds});
      end
      end_test();

      begin_test("uart_loopback");
      repeat (8) begin
         b = 8'($urandom);
         write_word(16'h5000, {24'd0, b}, 4'h1);
         read_checked(16'h5004, 32'h1);           // busy, nothing received
         write_word(16'h5000, {24'd0, ~b}, 4'h1); // dropped
         polls = 0;
         d = '0;
         while (d != 32'h2 && polls < 200) begin
            read_now(16'h5004, d);
            polls++;
         end
         assert (d == 32'h2) else report_problem("rx_valid never set with the transmitter idle");
         read_checked(16'h5000, {24'd0, b});
         read_checked(16'h5004, 32'h0);
      end
      end_test();

      begin_test("pipelined");
      repeat (200) begin
         case ($urandom_range(4))
            0, 1:    read_word(pick_written());
            2:       read_word({4'b0100, 12'($urandom)});
            3:       read_word({3'b011, 13'($urandom)});
            default: read_checked(16'h5004, 32'h0);
         endcase
      end
      end_test();

      $display("tests passed %0d failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0 && uut.checks.fail_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- flist.f
machine_pkg.sv
bus_decoder.sv
ram.sv
led.sv
uart.sv
machine.sv
tb_clock.sv
machine_assertions.sv
machine_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module machine_tb -f flist.f -o machine_sim || exit 1
out=$(./obj_dir/machine_sim)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
